/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the management register block simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module mgmt_regs_tb -o mgmt_regs_sim
./obj_dir/mgmt_regs_sim 2>&1 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* sim/mgmt_regs_checker.sv */
`timescale 1ns/1ps

module mgmt_regs_checker (
	input logic clk,
	input logic rst_n,
	input logic rd_en,
	input mgmt_pkg::regaddr_t rd_addr,
	input logic rd_valid,
	input logic relay_en,
	input logic front_shift_en
);

	logic rd_pending;

	// Request seen and not yet answered
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_pending <= 1'b0;
		else if (rd_en)
			rd_pending <= 1'b1;
		else if (rd_valid)
			rd_pending <= 1'b0;
	end

	////////////////////
	// Single-cycle pulses

	a_rd_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |=> !rd_valid) else $error("rd_valid high for two cycles");
	a_relay_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		relay_en |=> !relay_en) else $error("relay_en high for two cycles");
	a_shift_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		front_shift_en |=> !front_shift_en) else $error("front_shift_en high for two cycles");

	////////////////////
	// Read handshake

	a_valid_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> rd_pending) else $error("rd_valid without a read request");
	// Held through the cycle that carries rd_valid
	a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rd_pending |-> $stable(rd_addr)) else $error("rd_addr changed during a read");

endmodule

bind mgmt_regs_top mgmt_regs_checker checker_i (
	.clk(clk),
	.rst_n(rst_n),
	.rd_en(rd_en),
	.rd_addr(rd_addr),
	.rd_valid(rd_valid),
	.relay_en(relay_en),
	.front_shift_en(front_shift_en)
);

/* sim/mgmt_regs_tb.sv */
`timescale 1ns/1ps

module mgmt_regs_tb;

	logic clk;
	logic rst_n;
	logic rd_en;
	mgmt_pkg::regaddr_t rd_addr;
	logic rd_valid;
	mgmt_pkg::regdata_t rd_data;
	logic wr_en;
	mgmt_pkg::regaddr_t wr_addr;
	mgmt_pkg::regdata_t wr_data;
	logic idcode_valid;
	logic [31:0] idcode;
	logic die_serial_valid;
	logic [63:0] die_serial;
	// Six sensors side by side, byte n sits at REG_FAN0_RPM+n
	logic [95:0] sensors;
	mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUX_CHANNELS-1:0] muxsel;
	logic relay_en;
	logic relay_dir;
	mgmt_pkg::relay_chan_t relay_channel;
	logic relay_done;
	mgmt_pkg::trig_led_t trig_in_led;
	mgmt_pkg::trig_led_t trig_out_led;
	logic front_shift_en;
	mgmt_pkg::regdata_t front_shift_data;
	logic front_shift_done;
	logic front_cs_n;

	// Expected state behind the status registers
	logic relay_busy_m;
	logic front_busy_m;
	logic [mgmt_pkg::NUM_RELAYS-1:0] relay_state_m;
	integer seed = 77;
	int wait_limit = 40;
	int reads_issued = 0;
	int reads_checked = 0;

	mgmt_regs_top dut_i (
		.clk(clk), .rst_n(rst_n),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.idcode_valid(idcode_valid), .idcode(idcode),
		.die_serial_valid(die_serial_valid), .die_serial(die_serial),
		.fan0_rpm(sensors[15:0]), .fan1_rpm(sensors[31:16]), .die_temp(sensors[47:32]),
		.volt_core(sensors[63:48]), .volt_ram(sensors[79:64]), .volt_aux(sensors[95:80]),
		.muxsel(muxsel),
		.relay_en(relay_en), .relay_dir(relay_dir), .relay_channel(relay_channel),
		.relay_done(relay_done),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led),
		.front_shift_en(front_shift_en), .front_shift_data(front_shift_data),
		.front_shift_done(front_shift_done), .front_cs_n(front_cs_n)
	);

	always #50 clk = ~clk;

	////////////////////
	// Reference model

	function automatic mgmt_pkg::regdata_t ref_read(input mgmt_pkg::regaddr_t addr);
		int off;
		logic [95:0] w;
		w = '0;
		// Device info comes out most significant byte first
		if (addr < mgmt_pkg::REG_FPGA_SERIAL) begin
			off = int'(addr - mgmt_pkg::REG_FPGA_IDCODE);
			w = {64'h0, idcode} >> (8 * (3 - off));
		end else if (addr < mgmt_pkg::REG_FPGA_SERIAL + mgmt_pkg::SERIAL_BYTES) begin
			off = int'(addr - mgmt_pkg::REG_FPGA_SERIAL);
			w = {32'h0, die_serial} >> (8 * (7 - off));
		end else if (addr >= mgmt_pkg::REG_FAN0_RPM &&
				addr <= mgmt_pkg::REG_VOLT_AUX + 16'd1) begin
			// Low byte first, so the byte offset walks straight through
			off = int'(addr - mgmt_pkg::REG_FAN0_RPM);
			w = sensors >> (8 * off);
		end else if (addr == mgmt_pkg::REG_FRONT_STAT)
			w[0] = front_busy_m;
		else if (addr == mgmt_pkg::REG_RELAY_STAT_1)
			w[0] = relay_busy_m;
		return w[7:0];
	endfunction

	function automatic mgmt_pkg::regdata_t led_ref(input int idx);
		mgmt_pkg::trig_led_t masked;
		mgmt_pkg::trig_led_t rev;
		mgmt_pkg::led_word_t w;
		// Output port of a relay in input mode stays dark
		masked = trig_out_led &
			~(mgmt_pkg::trig_led_t'(relay_state_m) << mgmt_pkg::RELAY_PORT_BASE);
		rev = {<<{trig_in_led}};
		w = {rev, masked};
		w = w >> (8 * idx);
		return w[7:0];
	endfunction

	////////////////////
	// Checks

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input mgmt_pkg::regdata_t got,
			input mgmt_pkg::regdata_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_muxsel(input string name, input mgmt_pkg::muxsel_t got,
			input mgmt_pkg::muxsel_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bank(input mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUX_CHANNELS-1:0] exp);
		logic [3:0] ch;
		for (ch = 0; ch < 4'(mgmt_pkg::NUM_MUX_CHANNELS); ch++)
			check_muxsel($sformatf("muxsel[%0d]", ch), muxsel[ch], exp[ch]);
	endtask

	// Every completed read against the model, sampled mid cycle
	always @(negedge clk) begin
		if (rst_n && rd_valid) begin
			check_data($sformatf("rd_data @0x%h", rd_addr), rd_data, ref_read(rd_addr));
			reads_checked++;
		end
	end

	////////////////////
	// Bus tasks

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input mgmt_pkg::regaddr_t addr, input mgmt_pkg::regdata_t data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		step_cycle();
		wr_en = 1'b0;
	endtask

	task automatic start_read(input mgmt_pkg::regaddr_t addr);
		rd_en = 1'b1;
		rd_addr = addr;
		reads_issued++;
		step_cycle();
		rd_en = 1'b0;
	endtask

	// Address stays put until the cycle after rd_valid
	task automatic wait_read();
		int n;
		n = 0;
		while (!rd_valid) begin
			if (n == wait_limit) begin
				$display("Timeout: read at 0x%h never returned rd_valid", rd_addr);
				stop_run();
			end
			step_cycle();
			n++;
		end
		step_cycle();
	endtask

	////////////////////
	// Stimulus

	initial begin
		mgmt_pkg::regaddr_t a;
		logic [3:0] ch;
		logic [31:0] rnd;
		mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUX_CHANNELS-1:0] exp_sel;
		mgmt_pkg::relay_chan_t chan;
		mgmt_pkg::regdata_t raw;

		clk = 1'b0;
		rst_n = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		idcode_valid = 1'b0;
		die_serial_valid = 1'b0;
		relay_done = 1'b0;
		front_shift_done = 1'b0;
		idcode = $random(seed);
		die_serial = {$random(seed), $random(seed)};
		sensors = {$random(seed), $random(seed), $random(seed)};
		trig_in_led = '0;
		trig_out_led = '0;
		relay_busy_m = 1'b0;
		front_busy_m = 1'b0;
		relay_state_m = '0;
		exp_sel = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Reset values
		check_flag("rd_valid", rd_valid, 1'b0);
		check_flag("relay_en", relay_en, 1'b0);
		check_flag("front_shift_en", front_shift_en, 1'b0);
		check_flag("front_cs_n", front_cs_n, 1'b1);
		check_bank(exp_sel);

		// Sensors never stall
		for (a = mgmt_pkg::REG_FAN0_RPM; a <= mgmt_pkg::REG_VOLT_AUX + 16'd1; a++) begin
			start_read(a);
			check_flag("rd_valid", rd_valid, 1'b1);
			wait_read();
		end

		// Device info holds the read until its flag rises
		start_read(mgmt_pkg::REG_FPGA_IDCODE + 16'd1);
		repeat (6) begin
			check_flag("rd_valid", rd_valid, 1'b0);
			step_cycle();
		end
		idcode_valid = 1'b1;
		wait_read();
		start_read(mgmt_pkg::REG_FPGA_SERIAL + 16'd5);
		repeat (6) begin
			check_flag("rd_valid", rd_valid, 1'b0);
			step_cycle();
		end
		die_serial_valid = 1'b1;
		wait_read();
		for (a = mgmt_pkg::REG_FPGA_IDCODE;
				a < mgmt_pkg::REG_FPGA_SERIAL + mgmt_pkg::SERIAL_BYTES; a++) begin
			start_read(a);
			wait_read();
		end

		// Selector bank, then writes past the last channel
		for (ch = 0; ch < 4'(mgmt_pkg::NUM_MUX_CHANNELS); ch++) begin
			rnd = $random(seed);
			exp_sel[ch] = rnd[3:0];
			bus_write(mgmt_pkg::REG_MUXSEL_BASE + {12'h0, ch}, rnd[7:0]);
			check_muxsel($sformatf("muxsel[%0d]", ch), muxsel[ch], exp_sel[ch]);
		end
		for (ch = 4'(mgmt_pkg::NUM_MUX_CHANNELS); ch < 4'd15; ch++)
			bus_write(mgmt_pkg::REG_MUXSEL_BASE + {12'h0, ch}, 8'hff);
		check_bank(exp_sel);

		// Relay switched to input on a random channel
		rnd = $random(seed);
		chan = rnd[1:0];
		bus_write(mgmt_pkg::REG_RELAY_TOGGLE, {6'h0, chan});
		check_flag("relay_en", relay_en, 1'b0);
		bus_write(mgmt_pkg::REG_RELAY_TOGGLE_1, 8'h80);
		check_flag("relay_en", relay_en, 1'b1);
		check_flag("relay_dir", relay_dir, 1'b1);
		check_data("relay_channel", mgmt_pkg::regdata_t'(relay_channel), {6'h0, chan});
		step_cycle();
		check_flag("relay_en", relay_en, 1'b0);
		relay_busy_m = 1'b1;
		relay_state_m[chan] = 1'b1;
		start_read(mgmt_pkg::REG_RELAY_STAT_1);
		wait_read();
		start_read(mgmt_pkg::REG_RELAY_STAT);
		wait_read();
		relay_done = 1'b1;
		step_cycle();
		relay_done = 1'b0;
		relay_busy_m = 1'b0;
		start_read(mgmt_pkg::REG_RELAY_STAT_1);
		wait_read();

		// Front panel raw byte and busy flag
		bus_write(mgmt_pkg::REG_FRONT_CTRL, 8'h00);
		check_flag("front_cs_n", front_cs_n, 1'b0);
		rnd = $random(seed);
		raw = rnd[7:0];
		bus_write(mgmt_pkg::REG_FRONT_DATA, raw);
		check_flag("front_shift_en", front_shift_en, 1'b1);
		check_data("front_shift_data", front_shift_data, raw);
		step_cycle();
		front_busy_m = 1'b1;
		start_read(mgmt_pkg::REG_FRONT_STAT);
		wait_read();
		front_shift_done = 1'b1;
		step_cycle();
		front_shift_done = 1'b0;
		front_busy_m = 1'b0;
		start_read(mgmt_pkg::REG_FRONT_STAT);
		wait_read();

		// LED push, the switched relay's port lit so the mask shows
		rnd = $random(seed);
		trig_in_led = rnd[11:0];
		trig_out_led = rnd[27:16] |
			(mgmt_pkg::trig_led_t'(relay_state_m) << mgmt_pkg::RELAY_PORT_BASE);
		for (int i = 0; i < 3; i++) begin
			bus_write(mgmt_pkg::REG_FRONT_LED_0 + mgmt_pkg::regaddr_t'(i), 8'h00);
			check_flag("front_shift_en", front_shift_en, 1'b1);
			check_data($sformatf("led byte %0d", i), front_shift_data, led_ref(i));
			step_cycle();
			front_shift_done = 1'b1;
			step_cycle();
			front_shift_done = 1'b0;
		end
		bus_write(mgmt_pkg::REG_FRONT_CTRL, 8'h01);
		check_flag("front_cs_n", front_cs_n, 1'b1);

		if (reads_checked != reads_issued) begin
			$display("Compare process saw %0d reads but %0d were issued",
				reads_checked, reads_issued);
			stop_run();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

/* verilog/front_panel_ctrl.sv */
`timescale 1ns/1ps

module front_panel_ctrl (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input mgmt_pkg::regaddr_t wr_addr,
	input mgmt_pkg::regdata_t wr_data,
	input logic front_shift_done,
	input mgmt_pkg::trig_led_t trig_in_led,
	input mgmt_pkg::trig_led_t trig_out_led,
	input logic [mgmt_pkg::NUM_RELAYS-1:0] relay_state,
	output logic front_shift_en,
	output mgmt_pkg::regdata_t front_shift_data,
	output logic front_cs_n,
	output logic front_busy
);

	mgmt_pkg::led_word_t led_word;
	logic launch;
	mgmt_pkg::regdata_t launch_data;

	////////////////////
	// LED word assembly

	always_comb begin
		led_word[mgmt_pkg::NUM_TRIG_PORTS-1:0] = trig_out_led;
		// Port switched to input by its relay never shows as an active output
		for (int n = 0; n < mgmt_pkg::NUM_RELAYS; n++) begin
			if (relay_state[n])
				led_word[mgmt_pkg::RELAY_PORT_BASE + n] = 1'b0;
		end
		// Input LEDs run in the opposite order on the panel
		for (int i = 0; i < mgmt_pkg::NUM_TRIG_PORTS; i++)
			led_word[mgmt_pkg::NUM_TRIG_PORTS + i] =
				trig_in_led[mgmt_pkg::NUM_TRIG_PORTS - 1 - i];
	end

	////////////////////
	// Byte launch decode

	always_comb begin
		launch = wr_en;
		launch_data = wr_data;
		case (wr_addr)
			mgmt_pkg::REG_FRONT_DATA:  launch_data = wr_data;
			mgmt_pkg::REG_FRONT_LED_0: launch_data = led_word[7:0];
			mgmt_pkg::REG_FRONT_LED_1: launch_data = led_word[15:8];
			mgmt_pkg::REG_FRONT_LED_2: launch_data = led_word[23:16];
			default:                   launch = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			front_shift_en <= 1'b0;
			front_shift_data <= '0;
			front_cs_n <= 1'b1;
			front_busy <= 1'b0;
		end else begin
			front_shift_en <= launch;
			if (launch)
				front_shift_data <= launch_data;
			// Chip select is driven straight from bit 0
			if (wr_en && (wr_addr == mgmt_pkg::REG_FRONT_CTRL))
				front_cs_n <= wr_data[0];

			// Shifter busy until it signals done
			if (front_shift_done)
				front_busy <= 1'b0;
			if (front_shift_en)
				front_busy <= 1'b1;
		end
	end

endmodule

/* verilog/mgmt_pkg.sv */
package mgmt_pkg;

	////////////////////
	// Bus and field widths

	// Management bus carries 16-bit addresses and byte data
	typedef logic [15:0] regaddr_t;
	typedef logic [7:0] regdata_t;

	// Sensor readings are split across two byte registers
	typedef logic [15:0] sensor_t;

	localparam int MUXSEL_BITS = 4;
	localparam int NUM_MUX_CHANNELS = 12;
	localparam int NUM_TRIG_PORTS = 12;
	localparam int NUM_RELAYS = 4;

	// Output port RELAY_PORT_BASE+n is switched by relay n
	localparam int RELAY_PORT_BASE = 8;

	typedef logic [MUXSEL_BITS-1:0] muxsel_t;
	typedef logic [$clog2(NUM_RELAYS)-1:0] relay_chan_t;
	typedef logic [NUM_TRIG_PORTS-1:0] trig_led_t;

	// Outputs in the low half, inputs reversed in the high half
	typedef logic [2*NUM_TRIG_PORTS-1:0] led_word_t;

	////////////////////
	// Register map

	// Device info blocks span several byte addresses
	localparam regaddr_t IDCODE_BYTES = 16'd4;
	localparam regaddr_t SERIAL_BYTES = 16'd8;

	localparam regaddr_t REG_FPGA_IDCODE = 16'h0000;
	localparam regaddr_t REG_FPGA_SERIAL = 16'h0004;

	// Sensors, low byte at the even address
	localparam regaddr_t REG_FAN0_RPM = 16'h0010;
	localparam regaddr_t REG_FAN1_RPM = 16'h0012;
	localparam regaddr_t REG_DIE_TEMP = 16'h0014;
	localparam regaddr_t REG_VOLT_CORE = 16'h0016;
	localparam regaddr_t REG_VOLT_RAM = 16'h0018;
	localparam regaddr_t REG_VOLT_AUX = 16'h001a;

	// Front panel SPI path
	localparam regaddr_t REG_FRONT_CTRL = 16'h0050;
	localparam regaddr_t REG_FRONT_DATA = 16'h0051;
	localparam regaddr_t REG_FRONT_STAT = 16'h0052;
	localparam regaddr_t REG_FRONT_LED_0 = 16'h0053;
	localparam regaddr_t REG_FRONT_LED_1 = 16'h0054;
	localparam regaddr_t REG_FRONT_LED_2 = 16'h0055;

	// Relay controller
	localparam regaddr_t REG_RELAY_TOGGLE = 16'h0070;
	localparam regaddr_t REG_RELAY_TOGGLE_1 = 16'h0071;
	localparam regaddr_t REG_RELAY_STAT = 16'h0072;
	localparam regaddr_t REG_RELAY_STAT_1 = 16'h0073;

	// First crossbar selector, the rest follow one per address
	localparam regaddr_t REG_MUXSEL_BASE = 16'h00f0;

	////////////////////
	// Read decoder FSM

	typedef enum logic {
		RD_IDLE,
		RD_WAIT
	} rd_state_t;

endpackage

/* verilog/mgmt_read_decoder.sv */
`timescale 1ns/1ps

module mgmt_read_decoder (
	input logic clk,
	input logic rst_n,
	input logic rd_en,
	input mgmt_pkg::regaddr_t rd_addr,
	input logic idcode_valid,
	input logic [31:0] idcode,
	input logic die_serial_valid,
	input logic [63:0] die_serial,
	input mgmt_pkg::sensor_t fan0_rpm,
	input mgmt_pkg::sensor_t fan1_rpm,
	input mgmt_pkg::sensor_t die_temp,
	input mgmt_pkg::sensor_t volt_core,
	input mgmt_pkg::sensor_t volt_ram,
	input mgmt_pkg::sensor_t volt_aux,
	input logic relay_busy,
	input logic front_busy,
	output logic rd_valid,
	output mgmt_pkg::regdata_t rd_data
);

	mgmt_pkg::rd_state_t rd_state;
	mgmt_pkg::regaddr_t idcode_off;
	mgmt_pkg::regaddr_t serial_off;
	logic idcode_hit;
	logic serial_hit;
	logic data_wait;
	logic rd_active;
	mgmt_pkg::regdata_t rd_mux;

	////////////////////
	// Data-ready stall

	// Offsets wrap for addresses below the block, so one compare covers the range
	assign idcode_off = rd_addr - mgmt_pkg::REG_FPGA_IDCODE;
	assign serial_off = rd_addr - mgmt_pkg::REG_FPGA_SERIAL;
	assign idcode_hit = idcode_off < mgmt_pkg::IDCODE_BYTES;
	assign serial_hit = serial_off < mgmt_pkg::SERIAL_BYTES;

	// Hold the read while the addressed device info is not yet latched
	assign data_wait = (idcode_hit && !idcode_valid) || (serial_hit && !die_serial_valid);

	// New request or one still pending
	assign rd_active = rd_en || (rd_state == mgmt_pkg::RD_WAIT);

	////////////////////
	// Read data mux

	always_comb begin
		rd_mux = '0;
		// Device info is big endian, lowest address gets the top byte
		if (idcode_hit)
			rd_mux = idcode[{~idcode_off[1:0], 3'b000} +: 8];
		else if (serial_hit)
			rd_mux = die_serial[{~serial_off[2:0], 3'b000} +: 8];
		else begin
			case (rd_addr)
				// Sensors, low byte first
				mgmt_pkg::REG_FAN0_RPM:          rd_mux = fan0_rpm[7:0];
				mgmt_pkg::REG_FAN0_RPM + 16'd1:  rd_mux = fan0_rpm[15:8];
				mgmt_pkg::REG_FAN1_RPM:          rd_mux = fan1_rpm[7:0];
				mgmt_pkg::REG_FAN1_RPM + 16'd1:  rd_mux = fan1_rpm[15:8];
				mgmt_pkg::REG_DIE_TEMP:          rd_mux = die_temp[7:0];
				mgmt_pkg::REG_DIE_TEMP + 16'd1:  rd_mux = die_temp[15:8];
				mgmt_pkg::REG_VOLT_CORE:         rd_mux = volt_core[7:0];
				mgmt_pkg::REG_VOLT_CORE + 16'd1: rd_mux = volt_core[15:8];
				mgmt_pkg::REG_VOLT_RAM:          rd_mux = volt_ram[7:0];
				mgmt_pkg::REG_VOLT_RAM + 16'd1:  rd_mux = volt_ram[15:8];
				mgmt_pkg::REG_VOLT_AUX:          rd_mux = volt_aux[7:0];
				mgmt_pkg::REG_VOLT_AUX + 16'd1:  rd_mux = volt_aux[15:8];
				// Status flags in bit 0
				mgmt_pkg::REG_FRONT_STAT:        rd_mux = {7'b0, front_busy};
				mgmt_pkg::REG_RELAY_STAT:        rd_mux = 8'h00;
				mgmt_pkg::REG_RELAY_STAT_1:      rd_mux = {7'b0, relay_busy};
				default:                         rd_mux = 8'h00;
			endcase
		end
	end

	////////////////////
	// Read FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= mgmt_pkg::RD_IDLE;
			rd_valid <= 1'b0;
			rd_data <= '0;
		end else begin
			rd_valid <= 1'b0;
			if (rd_active) begin
				if (data_wait)
					rd_state <= mgmt_pkg::RD_WAIT;
				else begin
					// Data ready, complete on the next cycle
					rd_valid <= 1'b1;
					rd_data <= rd_mux;
					rd_state <= mgmt_pkg::RD_IDLE;
				end
			end
		end
	end

endmodule

/* verilog/mgmt_regs_top.sv */
`timescale 1ns/1ps

module mgmt_regs_top (
	input logic clk,
	input logic rst_n,

	// Register bus
	input logic rd_en,
	input mgmt_pkg::regaddr_t rd_addr,
	output logic rd_valid,
	output mgmt_pkg::regdata_t rd_data,
	input logic wr_en,
	input mgmt_pkg::regaddr_t wr_addr,
	input mgmt_pkg::regdata_t wr_data,

	// Device info, flags rise once the value is latched
	input logic idcode_valid,
	input logic [31:0] idcode,
	input logic die_serial_valid,
	input logic [63:0] die_serial,

	// Sensors
	input mgmt_pkg::sensor_t fan0_rpm,
	input mgmt_pkg::sensor_t fan1_rpm,
	input mgmt_pkg::sensor_t die_temp,
	input mgmt_pkg::sensor_t volt_core,
	input mgmt_pkg::sensor_t volt_ram,
	input mgmt_pkg::sensor_t volt_aux,

	// Crossbar selectors
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUX_CHANNELS-1:0] muxsel,

	// Relay controller
	output logic relay_en,
	output logic relay_dir,
	output mgmt_pkg::relay_chan_t relay_channel,
	input logic relay_done,

	// Front panel
	input mgmt_pkg::trig_led_t trig_in_led,
	input mgmt_pkg::trig_led_t trig_out_led,
	output logic front_shift_en,
	output mgmt_pkg::regdata_t front_shift_data,
	input logic front_shift_done,
	output logic front_cs_n
);

	logic relay_busy;
	logic front_busy;
	logic [mgmt_pkg::NUM_RELAYS-1:0] relay_state;

	mgmt_read_decoder u_read_decoder (
		.clk(clk), .rst_n(rst_n),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.idcode_valid(idcode_valid), .idcode(idcode),
		.die_serial_valid(die_serial_valid), .die_serial(die_serial),
		.fan0_rpm(fan0_rpm), .fan1_rpm(fan1_rpm), .die_temp(die_temp),
		.volt_core(volt_core), .volt_ram(volt_ram), .volt_aux(volt_aux),
		.relay_busy(relay_busy), .front_busy(front_busy)
	);

	// Write bus fans out, each block decodes its own addresses
	relay_tracker u_relay_tracker (
		.clk(clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.relay_done(relay_done), .relay_en(relay_en), .relay_dir(relay_dir),
		.relay_channel(relay_channel), .relay_busy(relay_busy), .relay_state(relay_state)
	);

	front_panel_ctrl u_front_panel_ctrl (
		.clk(clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.front_shift_done(front_shift_done),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led), .relay_state(relay_state),
		.front_shift_en(front_shift_en), .front_shift_data(front_shift_data),
		.front_cs_n(front_cs_n), .front_busy(front_busy)
	);

	muxsel_bank u_muxsel_bank (
		.clk(clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.muxsel(muxsel)
	);

endmodule

/* verilog/muxsel_bank.sv */
`timescale 1ns/1ps

module muxsel_bank (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input mgmt_pkg::regaddr_t wr_addr,
	input mgmt_pkg::regdata_t wr_data,
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUX_CHANNELS-1:0] muxsel
);

	logic [mgmt_pkg::NUM_MUX_CHANNELS-1:0] sel_hit;

	// One address per output channel, anything past the last is ignored
	always_comb begin
		for (int k = 0; k < mgmt_pkg::NUM_MUX_CHANNELS; k++)
			sel_hit[k] = wr_en &&
				(wr_addr == mgmt_pkg::REG_MUXSEL_BASE + mgmt_pkg::regaddr_t'(k));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			muxsel <= '0;
		else begin
			for (int k = 0; k < mgmt_pkg::NUM_MUX_CHANNELS; k++) begin
				// Selector lives in the low nibble
				if (sel_hit[k])
					muxsel[k] <= wr_data[mgmt_pkg::MUXSEL_BITS-1:0];
			end
		end
	end

endmodule

/* verilog/relay_tracker.sv */
`timescale 1ns/1ps

module relay_tracker (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input mgmt_pkg::regaddr_t wr_addr,
	input mgmt_pkg::regdata_t wr_data,
	input logic relay_done,
	output logic relay_en,
	output logic relay_dir,
	output mgmt_pkg::relay_chan_t relay_channel,
	output logic relay_busy,
	output logic [mgmt_pkg::NUM_RELAYS-1:0] relay_state
);

	logic toggle_wr;
	logic fire_wr;

	// Low byte picks the channel, high byte carries direction and fires
	assign toggle_wr = wr_en && (wr_addr == mgmt_pkg::REG_RELAY_TOGGLE);
	assign fire_wr = wr_en && (wr_addr == mgmt_pkg::REG_RELAY_TOGGLE_1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			relay_en <= 1'b0;
			relay_dir <= 1'b0;
			relay_channel <= '0;
			relay_busy <= 1'b0;
			relay_state <= '0;
		end else begin
			relay_en <= fire_wr;
			if (toggle_wr)
				relay_channel <= wr_data[$bits(mgmt_pkg::relay_chan_t)-1:0];
			// Bit 7 set means the port becomes an input
			if (fire_wr)
				relay_dir <= wr_data[7];

			// Busy from command launch until the driver reports done
			if (relay_done)
				relay_busy <= 1'b0;
			if (relay_en)
				relay_busy <= 1'b1;

			// Remember each channel's direction for the LED masking
			if (relay_en)
				relay_state[relay_channel] <= relay_dir;
		end
	end

endmodule

/* vlog.f */
verilog/mgmt_pkg.sv
verilog/mgmt_read_decoder.sv
verilog/relay_tracker.sv
verilog/front_panel_ctrl.sv
verilog/muxsel_bank.sv
verilog/mgmt_regs_top.sv
sim/mgmt_regs_checker.sv
sim/mgmt_regs_tb.sv
